// File: hdl/FpTypes.sv
// Shared types and constants of the binary32 execution block.
// Holds the opcode set, the field widths, the flag layout and the class mask.
`default_nettype none

package FpTypes;

    localparam int ExpWidth  = 8;   // Binary32 exponent field.
    localparam int FracWidth = 23;  // Binary32 fraction field.

    typedef logic [31:0]          fp32_t;    // Raw binary32 value.
    typedef logic [31:0]          word_t;    // Integer register value.
    typedef logic [4:0]           fflags_t;  // NV, DZ, OF, UF, NX.
    typedef logic [ExpWidth-1:0]  exp_t;
    typedef logic [FracWidth-1:0] frac_t;

    localparam fflags_t FlagNv = 5'b1_0000;  // Invalid operation.

    typedef enum logic [3:0] {
        OpMoveToInt = 4'd0,   // FMV.X.W
        OpMoveToFp  = 4'd1,   // FMV.W.X
        OpClass     = 4'd2,
        OpSgnj      = 4'd3,
        OpSgnjn     = 4'd4,
        OpSgnjx     = 4'd5,
        OpEq        = 4'd6,
        OpLt        = 4'd7,
        OpLe        = 4'd8,
        OpMin       = 4'd9,
        OpMax       = 4'd10
    } FpOp_t;

    // FCLASS mask bits in RISC-V order.
    localparam word_t ClassNegInf       = 32'h0000_0001;
    localparam word_t ClassNegNormal    = 32'h0000_0002;
    localparam word_t ClassNegSubnormal = 32'h0000_0004;
    localparam word_t ClassNegZero      = 32'h0000_0008;
    localparam word_t ClassPosZero      = 32'h0000_0010;
    localparam word_t ClassPosSubnormal = 32'h0000_0020;
    localparam word_t ClassPosNormal    = 32'h0000_0040;
    localparam word_t ClassPosInf       = 32'h0000_0080;
    localparam word_t ClassSignalingNan = 32'h0000_0100;
    localparam word_t ClassQuietNan     = 32'h0000_0200;

    localparam word_t CanonicalNan = 32'h7FC0_0000;  // Positive quiet NaN.

endpackage

`default_nettype wire

// File: hdl/FpSignInjector.sv
// Sign injection for FSGNJ, FSGNJN and FSGNJX.
`timescale 1ns/1ns
`default_nettype none

module FpSignInjector (
    input  FpTypes::FpOp_t op,
    input  FpTypes::fp32_t fpSrc1,
    input  FpTypes::fp32_t fpSrc2,
    output FpTypes::fp32_t fpResult
);
    import FpTypes::*;

    logic sign1;
    logic sign2;

    assign sign1 = fpSrc1[ExpWidth+FracWidth];  // Sign bit of source 1.
    assign sign2 = fpSrc2[ExpWidth+FracWidth];

    always_comb begin
        fpResult = '0;  // Codes of other units.
        case (op)
            OpSgnj:  fpResult = {sign2, fpSrc1[ExpWidth+FracWidth-1:0]};
            OpSgnjn: fpResult = {~sign2, fpSrc1[ExpWidth+FracWidth-1:0]};
            OpSgnjx: fpResult = {sign1 ^ sign2, fpSrc1[ExpWidth+FracWidth-1:0]};
            default: fpResult = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/FpComparator.sv
// Compare and min/max unit for FEQ, FLT, FLE, FMIN and FMAX.
// Orders operands by sign and magnitude and raises NV on NaN inputs.
`timescale 1ns/1ns
`default_nettype none

module FpComparator (
    input  FpTypes::FpOp_t   op,
    input  FpTypes::fp32_t   fpSrc1,
    input  FpTypes::fp32_t   fpSrc2,
    output FpTypes::word_t   intResult,
    output FpTypes::fp32_t   fpResult,
    output FpTypes::fflags_t flags
);
    import FpTypes::*;

    localparam int MagWidth = ExpWidth + FracWidth;

    logic  sign1;
    logic  sign2;
    exp_t  exp1;
    exp_t  exp2;
    frac_t frac1;
    frac_t frac2;
    logic  nan1;
    logic  nan2;
    logic  anyNan;
    logic  anySnan;
    logic  bothZero;
    logic  magLess;
    logic  magGreater;
    logic  relLess;    // +0 and -0 are equal.
    logic  relEqual;
    logic  totalLess;  // -0 below +0.

    assign sign1 = fpSrc1[MagWidth];
    assign sign2 = fpSrc2[MagWidth];
    assign exp1  = fpSrc1[FracWidth +: ExpWidth];
    assign exp2  = fpSrc2[FracWidth +: ExpWidth];
    assign frac1 = fpSrc1[FracWidth-1:0];
    assign frac2 = fpSrc2[FracWidth-1:0];

    assign nan1    = (exp1 == '1) && (frac1 != '0);
    assign nan2    = (exp2 == '1) && (frac2 != '0);
    assign anyNan  = nan1 || nan2;
    assign anySnan = (nan1 && !frac1[FracWidth-1]) || (nan2 && !frac2[FracWidth-1]);

    assign bothZero   = (fpSrc1[MagWidth-1:0] == '0) && (fpSrc2[MagWidth-1:0] == '0);
    assign magLess    = fpSrc1[MagWidth-1:0] < fpSrc2[MagWidth-1:0];
    assign magGreater = fpSrc2[MagWidth-1:0] < fpSrc1[MagWidth-1:0];
    assign relEqual   = (fpSrc1 == fpSrc2) || bothZero;

    always_comb begin
        if (sign1 != sign2) begin
            relLess   = sign1 && !bothZero;  // Negative side is lower.
            totalLess = sign1;
        end else begin
            relLess   = sign1 ? magGreater : magLess;  // Larger magnitude is lower when negative.
            totalLess = relLess;
        end
    end

    always_comb begin
        intResult = '0;
        fpResult  = '0;
        flags     = '0;
        case (op)
            OpEq: begin
                intResult = word_t'(!anyNan && relEqual);
                flags     = anySnan ? FlagNv : '0;  // Quiet compare.
            end
            OpLt: begin
                intResult = word_t'(!anyNan && relLess);
                flags     = anyNan ? FlagNv : '0;   // Signaling compare.
            end
            OpLe: begin
                intResult = word_t'(!anyNan && (relLess || relEqual));
                flags     = anyNan ? FlagNv : '0;
            end
            OpMin, OpMax: begin
                if (nan1 && nan2) begin
                    fpResult = CanonicalNan;
                end else if (nan1) begin
                    fpResult = fpSrc2;  // Other operand wins over one NaN.
                end else if (nan2) begin
                    fpResult = fpSrc1;
                end else if (op == OpMin) begin
                    fpResult = totalLess ? fpSrc1 : fpSrc2;
                end else begin
                    fpResult = totalLess ? fpSrc2 : fpSrc1;
                end
                flags = anySnan ? FlagNv : '0;
            end
            default: begin
                intResult = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/FpClassifier.sv
// FCLASS decoder.
// Maps one binary32 operand onto the ten-bit one-hot class mask.
`timescale 1ns/1ns
`default_nettype none

module FpClassifier (
    input  FpTypes::fp32_t fpSrc,
    output FpTypes::word_t classMask
);
    import FpTypes::*;

    logic  sign;
    exp_t  exponent;
    frac_t fraction;

    assign sign     = fpSrc[ExpWidth+FracWidth];
    assign exponent = fpSrc[FracWidth +: ExpWidth];
    assign fraction = fpSrc[FracWidth-1:0];

    always_comb begin
        if (exponent == '1) begin
            if (fraction == '0) begin
                classMask = sign ? ClassNegInf : ClassPosInf;
            end else if (fraction[FracWidth-1]) begin
                classMask = ClassQuietNan;  // Quiet bit set.
            end else begin
                classMask = ClassSignalingNan;
            end
        end else if (exponent == '0) begin
            if (fraction == '0) begin
                classMask = sign ? ClassNegZero : ClassPosZero;
            end else begin
                classMask = sign ? ClassNegSubnormal : ClassPosSubnormal;
            end
        end else begin
            classMask = sign ? ClassNegNormal : ClassPosNormal;
        end
    end

endmodule

`default_nettype wire

// File: hdl/Fp32Unit.sv
// Scalar binary32 execution block without rounding.
// Routes each operation to its unit and registers the selected result.
`timescale 1ns/1ns
`default_nettype none

module Fp32Unit (
    input  logic             clk,
    input  logic             arstN,
    input  logic             issue,
    input  FpTypes::FpOp_t   op,
    input  FpTypes::word_t   intSrc,
    input  FpTypes::fp32_t   fpSrc1,
    input  FpTypes::fp32_t   fpSrc2,
    output logic             resultValid,
    output FpTypes::word_t   intResult,
    output FpTypes::fp32_t   fpResult,
    output logic             writeFlags,
    output FpTypes::fflags_t writeFlagsValue
);
    import FpTypes::*;

    typedef enum logic [2:0] {
        UnitNone,
        UnitMove,
        UnitClass,
        UnitSign,
        UnitCmp
    } FpUnit_t;

    FpUnit_t unit;
    fp32_t   fpResultSign;
    word_t   intResultCmp;
    fp32_t   fpResultCmp;
    fflags_t flagsCmp;
    word_t   classMask;
    word_t   nextInt;
    fp32_t   nextFp;
    logic    nextWriteFlags;
    fflags_t nextFlagsValue;

    FpSignInjector signInjector (
        .op       (op),
        .fpSrc1   (fpSrc1),
        .fpSrc2   (fpSrc2),
        .fpResult (fpResultSign)
    );

    FpComparator comparator (
        .op        (op),
        .fpSrc1    (fpSrc1),
        .fpSrc2    (fpSrc2),
        .intResult (intResultCmp),
        .fpResult  (fpResultCmp),
        .flags     (flagsCmp)
    );

    FpClassifier classifier (
        .fpSrc     (fpSrc1),
        .classMask (classMask)
    );

    always_comb begin
        case (op)
            OpMoveToInt, OpMoveToFp:             unit = UnitMove;
            OpClass:                             unit = UnitClass;
            OpSgnj, OpSgnjn, OpSgnjx:            unit = UnitSign;
            OpEq, OpLt, OpLe, OpMin, OpMax:      unit = UnitCmp;
            default:                             unit = UnitNone;
        endcase
    end

    always_comb begin
        nextInt        = '0;
        nextFp         = '0;
        nextWriteFlags = 1'b0;
        nextFlagsValue = '0;
        case (unit)
            UnitMove: begin
                nextInt = (op == OpMoveToInt) ? fpSrc1 : '0;  // FMV.X.W
                nextFp  = (op == OpMoveToFp) ? intSrc : '0;   // FMV.W.X
            end
            UnitClass: begin
                nextInt = classMask;
            end
            UnitSign: begin
                nextFp = fpResultSign;
            end
            UnitCmp: begin
                nextInt        = intResultCmp;
                nextFp         = fpResultCmp;
                nextWriteFlags = 1'b1;
                nextFlagsValue = flagsCmp;
            end
            default: begin
                nextInt = '0;  // Unknown opcode gives an empty result.
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resultValid     <= 1'b0;
            writeFlags      <= 1'b0;
            intResult       <= '0;
            fpResult        <= '0;
            writeFlagsValue <= '0;
        end else begin
            resultValid <= issue;
            writeFlags  <= issue && nextWriteFlags;
            if (issue) begin
                intResult       <= nextInt;
                fpResult        <= nextFp;
                writeFlagsValue <= nextFlagsValue;  // Held between issues.
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/Fp32Unit_sva.sv
// Bound assertions for the binary32 execution block.
// Covers the reset state and the one-cycle issue to result timing.
`timescale 1ns/1ns
`default_nettype none

module Fp32UnitSva (
    input logic           clk,
    input logic           arstN,
    input logic           issue,
    input logic           resultValid,
    input logic           writeFlags,
    input FpTypes::word_t intResult,
    input FpTypes::fp32_t fpResult
);
    int assertFailures = 0;  // Read by the testbench top at the end.

    ResetState: assert property (@(posedge clk)
        $rose(arstN) |-> !resultValid && !writeFlags && intResult == '0 && fpResult == '0)
        else begin
            $error("Outputs not cleared when reset was released");
            assertFailures++;
        end

    IssueToValid: assert property (@(posedge clk) disable iff (!arstN)
        issue |=> resultValid)
        else begin
            $error("resultValid missing one cycle after issue");
            assertFailures++;
        end

    IdleToInvalid: assert property (@(posedge clk) disable iff (!arstN)
        !issue |=> !resultValid)
        else begin
            $error("resultValid high without an issue the cycle before");
            assertFailures++;
        end

    FlagsNeedValid: assert property (@(posedge clk) disable iff (!arstN)
        writeFlags |-> resultValid)
        else begin
            $error("writeFlags high without resultValid");
            assertFailures++;
        end

endmodule

`default_nettype wire

// File: tests/Fp32UnitChecker.sv
// Scoreboard for the binary32 execution block.
// Predicts each issued operation and compares it with the result one cycle later.
`timescale 1ns/1ns
`default_nettype none

module Fp32UnitChecker (
    input logic             clk,
    input logic             arstN,
    input logic             issue,
    input FpTypes::FpOp_t   op,
    input FpTypes::word_t   intSrc,
    input FpTypes::fp32_t   fpSrc1,
    input FpTypes::fp32_t   fpSrc2,
    input logic             resultValid,
    input FpTypes::word_t   intResult,
    input FpTypes::fp32_t   fpResult,
    input logic             writeFlags,
    input FpTypes::fflags_t writeFlagsValue
);
    import FpTypes::*;

    // Expected entry is {intResult, fpResult, writeFlags, flags}.
    logic [69:0] expected[$];
    logic [69:0] want;
    logic        seenResult = 1'b0;
    int          testChecks = 0;
    int          testErrors = 0;
    int          totalChecks = 0;
    int          totalErrors = 0;
    int          testCount = 0;
    int          testsFailed = 0;

    function automatic logic isNan(fp32_t x);
        return x[30:23] == 8'hFF && x[22:0] != '0;
    endfunction

    function automatic logic isSignaling(fp32_t x);
        return isNan(x) && !x[22];
    endfunction

    // Signed key where both zeros map to 0 and order follows the real line.
    function automatic int orderKey(fp32_t x);
        return x[31] ? -int'({1'b0, x[30:0]}) : int'({1'b0, x[30:0]});
    endfunction

    function automatic word_t classOf(fp32_t x);
        int idx;
        if (isNan(x)) begin
            return x[22] ? ClassQuietNan : ClassSignalingNan;
        end
        if (x[30:23] == 8'hFF) idx = 0;        // Infinity.
        else if (x[30:23] != 8'h00) idx = 1;   // Normal.
        else if (x[22:0] != '0) idx = 2;       // Subnormal.
        else idx = 3;                          // Zero.
        return x[31] ? (word_t'(1) << idx) : (word_t'(1) << (7 - idx));
    endfunction

    function automatic logic [69:0] expectedOutputs(FpOp_t o, word_t src, fp32_t a, fp32_t b);
        word_t   iRes;
        fp32_t   fRes;
        logic    wf;
        fflags_t fl;
        logic    aFirst;
        iRes = '0;
        fRes = '0;
        wf   = 1'b0;
        fl   = '0;
        // Total order for min/max puts -0 below +0.
        aFirst = (orderKey(a) < orderKey(b)) || (orderKey(a) == orderKey(b) && a[31]);
        case (o)
            OpMoveToInt: iRes = a;
            OpMoveToFp:  fRes = src;
            OpClass:     iRes = classOf(a);
            OpSgnj:      fRes = {b[31], a[30:0]};
            OpSgnjn:     fRes = {~b[31], a[30:0]};
            OpSgnjx:     fRes = {a[31] ^ b[31], a[30:0]};
            OpEq, OpLt, OpLe: begin
                wf = 1'b1;
                if (!isNan(a) && !isNan(b)) begin
                    if (o == OpEq) iRes = word_t'(orderKey(a) == orderKey(b));
                    if (o == OpLt) iRes = word_t'(orderKey(a) < orderKey(b));
                    if (o == OpLe) iRes = word_t'(orderKey(a) <= orderKey(b));
                end
                if (o == OpEq) fl = (isSignaling(a) || isSignaling(b)) ? FlagNv : '0;
                else fl = (isNan(a) || isNan(b)) ? FlagNv : '0;
            end
            OpMin, OpMax: begin
                wf = 1'b1;
                fl = (isSignaling(a) || isSignaling(b)) ? FlagNv : '0;
                if (isNan(a) && isNan(b)) fRes = CanonicalNan;
                else if (isNan(a)) fRes = b;
                else if (isNan(b)) fRes = a;
                else fRes = ((o == OpMin) == aFirst) ? a : b;
            end
            default: iRes = '0;
        endcase
        return {iRes, fRes, wf, fl};
    endfunction

    task automatic reportError(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        testErrors++;
    endtask

    task automatic compareField(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (exp !== got) begin
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, got);
            testErrors++;
        end
    endtask

    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            expected.delete();
        end else if (issue) begin
            if (expected.size() != 0) begin
                reportError("a result did not arrive one cycle after its issue");
                expected.delete();
            end
            expected.push_back(expectedOutputs(op, intSrc, fpSrc1, fpSrc2));
        end
    end

    // Outputs settle after the rising edge, so they are sampled on the falling one.
    always @(negedge clk) begin
        if (arstN) begin
            testChecks++;
            if (resultValid) begin
                seenResult = 1'b1;
                if (expected.size() == 0) begin
                    reportError("result appeared with no operation issued the cycle before");
                end else begin
                    want = expected.pop_front();
                    compareField("intResult", want[69:38], intResult);
                    compareField("fpResult", want[37:6], fpResult);
                    compareField("writeFlags", 32'(want[5]), 32'(writeFlags));
                    compareField("writeFlagsValue", 32'(want[4:0]), 32'(writeFlagsValue));
                end
            end else begin
                if (writeFlags) reportError("writeFlags high without resultValid");
                if (!seenResult && (intResult != '0 || fpResult != '0 || writeFlagsValue != '0))
                    reportError("data outputs not zero after reset");
            end
        end
    end

    task automatic finishTest(input string name);
        if (expected.size() != 0) begin
            reportError("results missing at the end of the test");
            expected.delete();
        end
        $display("Test %s: %0d checks, %0d errors", name, testChecks, testErrors);
        testCount++;
        if (testErrors != 0) testsFailed++;
        totalChecks += testChecks;
        totalErrors += testErrors;
        testChecks = 0;
        testErrors = 0;
    endtask

    task automatic summarize();
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 testCount, testsFailed, totalChecks, totalErrors);
    endtask

endmodule

`default_nettype wire

// File: tests/Fp32UnitTb.sv
// Testbench top of the binary32 execution block.
// Drives LFSR operands through every operation and reports the overall result.
`timescale 1ns/1ns
`default_nettype none

module Fp32UnitTb;
    import FpTypes::*;

    localparam int CycleLimit = 2000;  // About twice the ~1020 cycles of stimulus.

    logic    clk;
    logic    arstN;
    logic    issue;
    FpOp_t   op;
    word_t   intSrc;
    fp32_t   fpSrc1;
    fp32_t   fpSrc2;
    logic    resultValid;
    word_t   intResult;
    fp32_t   fpResult;
    logic    writeFlags;
    fflags_t writeFlagsValue;

    logic [31:0] lfsrState = 32'h6617_9059;
    int          cycles = 0;

    FpOp_t allOps[11] = '{OpMoveToInt, OpMoveToFp, OpClass, OpSgnj, OpSgnjn, OpSgnjx,
                          OpEq, OpLt, OpLe, OpMin, OpMax};
    FpOp_t signOps[3] = '{OpSgnj, OpSgnjn, OpSgnjx};
    FpOp_t cmpOps[5]  = '{OpEq, OpLt, OpLe, OpMin, OpMax};
    // Directed pairs: signed zeros, one quiet NaN, one signaling NaN, two NaNs.
    fp32_t dirA[6] = '{32'h8000_0000, 32'h0000_0000, 32'h7FC0_0000,
                       32'h3F80_0000, 32'h7FC0_0000, 32'h7F80_0001};
    fp32_t dirB[6] = '{32'h0000_0000, 32'h8000_0000, 32'h3F80_0000,
                       32'h7FA0_0000, 32'h7F80_0001, 32'hFF80_0001};

    Fp32Unit DUT (.*);

    Fp32UnitChecker scoreboard (.*);

    bind Fp32Unit Fp32UnitSva sva (.*);

    // Fibonacci LFSR, taps 32, 22, 2, 1.
    function automatic logic [31:0] nextBits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = {lfsrState[30:0],
                         lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    // A quarter of the draws get an extreme exponent for zeros, infinities and NaNs.
    function automatic fp32_t drawOperand();
        fp32_t      v;
        logic [2:0] kind;
        v = nextBits(32);
        if (nextBits(2) == 0) begin
            kind     = 3'(nextBits(3));
            v[30:23] = kind[0] ? 8'hFF : 8'h00;
            v[22:0]  = kind[1] ? 23'd0 : {kind[2], v[21:0]};  // Quiet bit set or cleared.
        end
        return v;
    endfunction

    task automatic issueOp(input FpOp_t nextOp, input word_t src, input fp32_t a, input fp32_t b);
        @(negedge clk);
        issue  = 1'b1;
        op     = nextOp;
        intSrc = src;
        fpSrc1 = a;
        fpSrc2 = b;
    endtask

    // One idle cycle lets the last result arrive.
    task automatic drainResults();
        @(negedge clk);
        issue = 1'b0;
        @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        fp32_t a;
        arstN  = 1'b0;
        issue  = 1'b0;
        op     = OpMoveToInt;
        intSrc = '0;
        fpSrc1 = '0;
        fpSrc2 = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        repeat (10) @(negedge clk);
        scoreboard.finishTest("reset");

        for (int i = 0; i < 50; i++) issueOp(OpMoveToInt, nextBits(32), drawOperand(), 32'h0);
        for (int i = 0; i < 50; i++) issueOp(OpMoveToFp, nextBits(32), drawOperand(), 32'h0);
        drainResults();
        scoreboard.finishTest("moves");

        for (int i = 0; i < 200; i++) issueOp(OpClass, nextBits(32), drawOperand(), drawOperand());
        drainResults();
        scoreboard.finishTest("classify");

        for (int i = 0; i < 150; i++) begin
            issueOp(signOps[nextBits(2) % 3], nextBits(32), drawOperand(), drawOperand());
        end
        drainResults();
        scoreboard.finishTest("sign injection");

        for (int i = 0; i < 300; i++) begin
            a = drawOperand();
            issueOp(cmpOps[nextBits(3) % 5], nextBits(32), a, (nextBits(3) == 0) ? a : drawOperand());
        end
        for (int p = 0; p < 6; p++) begin
            for (int k = 0; k < 5; k++) issueOp(cmpOps[k], 32'h0, dirA[p], dirB[p]);
        end
        drainResults();
        scoreboard.finishTest("compare");

        for (int i = 0; i < 200; i++) begin
            issueOp(allOps[nextBits(4) % 11], nextBits(32), drawOperand(), drawOperand());
        end
        drainResults();
        scoreboard.finishTest("back to back");

        scoreboard.summarize();
        if (scoreboard.totalErrors == 0 && DUT.sva.assertFailures == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
hdl/FpTypes.sv
hdl/FpSignInjector.sv
hdl/FpComparator.sv
hdl/FpClassifier.sv
hdl/Fp32Unit.sv
tests/Fp32Unit_sva.sv
tests/Fp32UnitChecker.sv
tests/Fp32UnitTb.sv

// File: run.sh
#!/bin/sh
# Builds the Fp32Unit testbench with Verilator, runs it and judges the log.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module Fp32UnitTb \
    --Mdir obj_dir -o Fp32UnitSim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/Fp32UnitSim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"
exit 0
